// ==== filelist.f ====
+incdir+hdl
hdl/spi_link_pkg.sv
hdl/cmd_pkg.sv
hdl/spi_byte_port.sv
hdl/cmd_framer.sv
hdl/cmd_executor.sv
hdl/trs_ctrl_top.sv
verif/tb_clock.sv
verif/tb_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_top
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_top.sv ====
`include "trs_macros.svh"

module tb_top
  import cmd_pkg::*;
();

  // SCK half-period in system clocks
  localparam int half       = 10;
  localparam int wait_limit = 400;

  // opcode numbers of the control link
  localparam logic [7:0] op_get_cookie       = 8'd0;
  localparam logic [7:0] op_get_version      = 8'd15;
  localparam logic [7:0] op_set_screen_color = 8'd17;
  localparam logic [7:0] op_send_keyb        = 8'd19;
  localparam logic [7:0] op_set_led          = 8'd26;
  localparam logic [7:0] op_set_esp_status   = 8'd32;
  localparam logic [7:0] op_unknown          = 8'd3;

  localparam int flag_spi_error = 0;
  localparam int flag_keyb      = 1;

  logic        clk;
  logic        cass_out_sel_n;
  logic        sck;
  logic        cs_n;
  logic        mosi;
  logic        miso;
  led_ctrl_t   led;
  esp_status_t esp_status;
  rgb_t        screen_color;
  logic        keyb_pressed;
  logic        spi_error;
  logic [31:0] rng_state;

  tb_clock #(.period(100), .reset_cycles(16)) u_clock (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n)
  );

  trs_ctrl_top dut (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .miso           (miso),
    .led            (led),
    .esp_status     (esp_status),
    .screen_color   (screen_color),
    .keyb_pressed   (keyb_pressed),
    .spi_error      (spi_error)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [7:0] rand_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[7:0];
  endfunction

  function automatic logic flag_value(input int sel);
    return (sel == flag_spi_error) ? spi_error : keyb_pressed;
  endfunction

  task automatic fail_stop();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      fail_stop();
    end
  endtask

  task automatic wait_flag(input int sel, input logic level, input string name);
    int n;
    n = 0;
    while (flag_value(sel) !== level && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (flag_value(sel) !== level) begin
      $display("timeout: %s did not reach %0b within %0d clocks", name, level, wait_limit);
      fail_stop();
    end
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    @(negedge clk);
    while (cass_out_sel_n !== 1'b1 && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (cass_out_sel_n !== 1'b1) begin
      $display("timeout: reset was never released");
      fail_stop();
    end
  endtask

  // frame edges leave time for the synchronizers and the select-time load
  task automatic begin_frame();
    cs_n = 1'b0;
    repeat (half) @(negedge clk);
  endtask

  task automatic end_frame();
    cs_n = 1'b1;
    repeat (half) @(negedge clk);
  endtask

  // SPI mode 0, MSB first, miso sampled at each SCK rise
  task automatic xfer_byte(input logic [7:0] tx, output logic [7:0] reply);
    logic [7:0] sr;
    sr    = tx;
    reply = '0;
    repeat (8) begin
      mosi = sr[7];
      sr   = {sr[6:0], 1'b0};
      repeat (half) @(negedge clk);
      reply = {reply[6:0], miso};
      sck   = 1'b1;
      repeat (half) @(negedge clk);
      sck = 1'b0;
    end
    repeat (half) @(negedge clk);
  endtask

  task automatic send_cmd(input logic [7:0] op, input int n, input logic [7:0] p0,
                          input logic [7:0] p1, input logic [7:0] p2);
    logic [7:0] junk;
    begin_frame();
    xfer_byte(op, junk);
    if (n > 0) xfer_byte(p0, junk);
    if (n > 1) xfer_byte(p1, junk);
    if (n > 2) xfer_byte(p2, junk);
    end_frame();
  endtask

  // reply shows up in the byte after the command
  // dummy byte is get_cookie, which needs no parameters
  task automatic query(input logic [7:0] op, output logic [7:0] reply);
    logic [7:0] junk;
    begin_frame();
    xfer_byte(op, junk);
    xfer_byte(op_get_cookie, reply);
    end_frame();
  endtask

  initial begin
    logic [7:0] rd;
    logic [7:0] p0;
    logic [7:0] p1;
    logic [7:0] p2;
    logic [2:0] led_sent;
    sck       = 1'b0;
    cs_n      = 1'b1;
    mosi      = 1'b0;
    rng_state = 32'd75790;

    wait_reset_release();

    // reset values
    check_value("spi_error", 32'd0, 32'(spi_error));
    check_value("keyb_pressed", 32'd0, 32'(keyb_pressed));
    check_value("led", 32'd0, 32'({led.blue, led.green, led.red}));
    check_value("esp_status", 32'd0, 32'(esp_status));
    check_value("screen_color", 32'h00ff_ffff, 32'(screen_color));
    check_value("miso", 32'd0, 32'(miso));

    query(op_get_cookie, rd);
    check_value("cookie reply", 32'(`TRS_COOKIE), 32'(rd));
    query(op_get_version, rd);
    check_value("version reply", 32'({`TRS_VERSION_MAJOR, `TRS_VERSION_MINOR}), 32'(rd));
    check_value("miso", 32'd0, 32'(miso));

    p0       = rand_byte();
    led_sent = p0[2:0];
    send_cmd(op_set_led, 1, p0, 8'd0, 8'd0);
    check_value("led", 32'(p0[2:0]), 32'({led.blue, led.green, led.red}));

    p0 = rand_byte();
    send_cmd(op_set_esp_status, 1, p0, 8'd0, 8'd0);
    check_value("esp_status", 32'(p0), 32'(esp_status));

    p0 = rand_byte();
    p1 = rand_byte();
    p2 = rand_byte();
    send_cmd(op_set_screen_color, 3, p0, p1, p2);
    check_value("screen_color.red", 32'(p0), 32'(screen_color.red));
    check_value("screen_color.green", 32'(p1), 32'(screen_color.green));
    check_value("screen_color.blue", 32'(p2), 32'(screen_color.blue));

    // keyboard row 3 pressed then released
    p1 = rand_byte() | 8'h01;
    send_cmd(op_send_keyb, 2, 8'd3, p1, 8'd0);
    wait_flag(flag_keyb, 1'b1, "keyb_pressed");
    send_cmd(op_send_keyb, 2, 8'd3, 8'd0, 8'd0);
    wait_flag(flag_keyb, 1'b0, "keyb_pressed");

    // row 11 wraps onto row 3
    send_cmd(op_send_keyb, 2, 8'd11, p1, 8'd0);
    wait_flag(flag_keyb, 1'b1, "keyb_pressed");
    send_cmd(op_send_keyb, 2, 8'd3, 8'd0, 8'd0);
    wait_flag(flag_keyb, 1'b0, "keyb_pressed");

    send_cmd(op_unknown, 0, 8'd0, 8'd0, 8'd0);
    wait_flag(flag_spi_error, 1'b1, "spi_error");

    // flip every led bit so the update is visible
    p0      = rand_byte();
    p0[2:0] = ~led_sent;
    send_cmd(op_set_led, 1, p0, 8'd0, 8'd0);
    check_value("led", 32'(p0[2:0]), 32'({led.blue, led.green, led.red}));
    check_value("spi_error", 32'd1, 32'(spi_error));

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== verif/tb_clock.sv ====
module tb_clock #(
  parameter int period       = 100,
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic cass_out_sel_n
);

  initial begin
    clk = 1'b0;
  end

  always #(period / 2) clk = ~clk;

  // release on a falling edge, away from the DUT's active edge
  initial begin
    cass_out_sel_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    cass_out_sel_n = 1'b1;
  end

endmodule

// ==== hdl/trs_ctrl_top.sv ====
module trs_ctrl_top
  import spi_link_pkg::*;
  import cmd_pkg::*;
(
  input  logic        clk,
  input  logic        cass_out_sel_n,
  input  logic        sck,
  input  logic        cs_n,
  input  logic        mosi,
  output logic        miso,
  output led_ctrl_t   led,
  output esp_status_t esp_status,
  output rgb_t        screen_color,
  output logic        keyb_pressed,
  output logic        spi_error
);

  rx_byte_t   rx;
  cmd_t       cmd;
  resp_byte_u resp;

  spi_byte_port u_byte_port (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .sck            (sck),
    .cs_n           (cs_n),
    .mosi           (mosi),
    .resp           (resp),
    .rx             (rx),
    .miso           (miso)
  );

  cmd_framer u_framer (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .rx             (rx),
    .cmd            (cmd),
    .spi_error      (spi_error)
  );

  cmd_executor u_executor (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .cmd            (cmd),
    .resp           (resp),
    .led            (led),
    .esp_status     (esp_status),
    .screen_color   (screen_color),
    .keyb_pressed   (keyb_pressed)
  );

endmodule

// ==== hdl/cmd_executor.sv ====
`include "trs_macros.svh"

module cmd_executor
  import spi_link_pkg::*;
  import cmd_pkg::*;
(
  input  logic        clk,
  input  logic        cass_out_sel_n,
  input  cmd_t        cmd,
  output resp_byte_u  resp,
  output led_ctrl_t   led,
  output esp_status_t esp_status,
  output rgb_t        screen_color,
  output logic        keyb_pressed
);

  localparam int row_w = $clog2(`TRS_KEYB_ROWS);

  resp_byte_u                     resp_q;
  led_ctrl_t                      led_q;
  esp_status_t                    esp_status_q;
  rgb_t                           screen_color_q;
  logic [`TRS_KEYB_ROWS-1:0][7:0] keyb_q;
  logic [row_w-1:0]               keyb_row;

  // row select wraps on the matrix size
  assign keyb_row = cmd.params[0][row_w-1:0];

  // settings registers
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_q          <= '0;
      esp_status_q   <= '0;
      screen_color_q <= '1;
    end else if (cmd.valid) begin
      case (cmd.opcode)
        set_led: begin
          led_q <= led_ctrl_t'(cmd.params[0][2:0]);
        end
        set_esp_status: begin
          esp_status_q <= esp_status_t'(cmd.params[0]);
        end
        set_screen_color: begin
          screen_color_q.red   <= cmd.params[0];
          screen_color_q.green <= cmd.params[1];
          screen_color_q.blue  <= cmd.params[2];
        end
        default: ;
      endcase
    end
  end

  // keyboard matrix, one row per send_keyb
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      keyb_q <= '0;
    end else if (cmd.valid && cmd.opcode == send_keyb) begin
      keyb_q[keyb_row] <= cmd.params[1];
    end
  end

  assign keyb_pressed = |keyb_q;

  // response byte, read by the byte port at the next byte boundary
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      resp_q.raw <= '0;
    end else if (cmd.valid) begin
      case (cmd.opcode)
        get_cookie: begin
          resp_q.raw <= `TRS_COOKIE;
        end
        get_version: begin
          resp_q.version.major <= `TRS_VERSION_MAJOR;
          resp_q.version.minor <= `TRS_VERSION_MINOR;
        end
        // anything else keeps the last answer
        default: ;
      endcase
    end
  end

  assign resp         = resp_q;
  assign led          = led_q;
  assign esp_status   = esp_status_q;
  assign screen_color = screen_color_q;

endmodule

// ==== hdl/cmd_framer.sv ====
`include "trs_macros.svh"

module cmd_framer
  import spi_link_pkg::*;
  import cmd_pkg::*;
(
  input  logic     clk,
  input  logic     cass_out_sel_n,
  input  rx_byte_t rx,
  output cmd_t     cmd,
  output logic     spi_error
);

  localparam int cnt_w = $clog2(`TRS_MAX_PARAMS + 1);

  typedef enum logic {
    idle,
    read_params
  } state_e;

  state_e                          state;
  logic [cnt_w-1:0]                need_cnt;
  logic                            known;
  logic [cnt_w-1:0]                need_q;
  logic [cnt_w-1:0]                idx;
  logic                            cmd_valid;
  opcode_e                         opcode_q;
  logic [`TRS_MAX_PARAMS-1:0][7:0] params_q;

  // parameter count per opcode
  always_comb begin
    known    = 1'b1;
    need_cnt = '0;
    case (rx.data)
      get_cookie,
      get_version:      need_cnt = cnt_w'(0);
      set_led,
      set_esp_status:   need_cnt = cnt_w'(1);
      send_keyb:        need_cnt = cnt_w'(2);
      set_screen_color: need_cnt = cnt_w'(3);
      default:          known    = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state     <= idle;
      need_q    <= '0;
      idx       <= '0;
      cmd_valid <= 1'b0;
      spi_error <= 1'b0;
    end else begin
      cmd_valid <= 1'b0;
      if (rx.valid) begin
        case (state)
          idle: begin
            idx <= '0;
            if (!known) begin
              // sticky until reset
              spi_error <= 1'b1;
            end else if (need_cnt == '0) begin
              cmd_valid <= 1'b1;
            end else begin
              need_q <= need_cnt;
              state  <= read_params;
            end
          end
          read_params: begin
            idx <= idx + cnt_w'(1);
            if (idx + cnt_w'(1) == need_q) begin
              cmd_valid <= 1'b1;
              state     <= idle;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // opcode and parameter bytes
  always_ff @(posedge clk) begin
    if (rx.valid) begin
      if (state == idle) begin
        opcode_q <= opcode_e'(rx.data);
      end else begin
        params_q[idx] <= rx.data;
      end
    end
  end

  assign cmd = '{valid: cmd_valid, opcode: opcode_q, params: params_q};

endmodule

// ==== hdl/spi_byte_port.sv ====
`include "trs_macros.svh"

module spi_byte_port
  import spi_link_pkg::*;
(
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  input  resp_byte_u resp,
  output rx_byte_t   rx,
  output logic       miso
);

  localparam int sync_w = `TRS_SYNC_STAGES;

  logic [sync_w-1:0] sck_sync;
  logic [sync_w-1:0] cs_n_sync;
  logic [sync_w-1:0] mosi_sync;
  logic              sck_q;
  logic              cs_n_q;
  logic              sck_s;
  logic              cs_n_s;
  logic              mosi_s;
  logic              sck_rise;
  logic              sck_fall;
  logic              cs_start;
  logic [2:0]        bit_cnt;
  logic              rx_valid;
  logic [7:0]        rx_shift;
  logic [7:0]        tx_shift;

  assign sck_s  = sck_sync[sync_w-1];
  assign cs_n_s = cs_n_sync[sync_w-1];
  assign mosi_s = mosi_sync[sync_w-1];

  // pin synchronizers, plus one extra stage on sck and cs_n for edge detect
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_sync  <= '0;
      cs_n_sync <= '1;
      mosi_sync <= '0;
      sck_q     <= 1'b0;
      cs_n_q    <= 1'b1;
    end else begin
      sck_sync  <= {sck_sync[sync_w-2:0], sck};
      cs_n_sync <= {cs_n_sync[sync_w-2:0], cs_n};
      mosi_sync <= {mosi_sync[sync_w-2:0], mosi};
      sck_q     <= sck_s;
      cs_n_q    <= cs_n_s;
    end
  end

  assign sck_rise = sck_s & ~sck_q;
  assign sck_fall = ~sck_s & sck_q;
  assign cs_start = ~cs_n_s & cs_n_q;

  // bit position within the byte, held at zero while deselected
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (cs_n_s) begin
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 3'd1;
        rx_valid <= (bit_cnt == 3'd7);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!cs_n_s && sck_rise) begin
      rx_shift <= {rx_shift[6:0], mosi_s};
    end
  end

  // byte completes on the same edge as the strobe and holds for a whole SCK period
  assign rx = '{valid: rx_valid, data: rx_shift};

  // reload at select and on the falling edge that closes each byte,
  // so bit 7 is on the pin before the master's first rising edge
  always_ff @(posedge clk) begin
    if (cs_start || (!cs_n_s && sck_fall && bit_cnt == 3'd0)) begin
      tx_shift <= resp.raw;
    end else if (!cs_n_s && sck_fall) begin
      tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  assign miso = ~cs_n_s & tx_shift[7];

endmodule

// ==== hdl/cmd_pkg.sv ====
`include "trs_macros.svh"

package cmd_pkg;

  // opcodes understood by the control link
  // numbering follows the microcontroller firmware, so the gaps are intentional
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    get_version      = 8'd15,
    set_screen_color = 8'd17,
    send_keyb        = 8'd19,
    set_led          = 8'd26,
    set_esp_status   = 8'd32
  } opcode_e;

  // one complete command
  // params[0] is the first byte after the opcode
  typedef struct packed {
    logic                                valid;
    opcode_e                             opcode;
    logic [`TRS_MAX_PARAMS-1:0][7:0]     params;
  } cmd_t;

  // board RGB led
  // red sits in bit 0 to match the set_led parameter byte
  typedef struct packed {
    logic blue;
    logic green;
    logic red;
  } led_ctrl_t;

  // status flags pushed down by the ESP
  typedef struct packed {
    logic [3:0] spare;
    logic       sd_mounted;
    logic       smb_mounted;
    logic       wifi_up;
    logic       esp_ready;
  } esp_status_t;

  // screen background color
  // byte order is the order the parameters arrive in
  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

endpackage

// ==== hdl/spi_link_pkg.sv ====
package spi_link_pkg;

  // byte from the SPI slave
  // valid is a single-cycle strobe, data holds until the next byte
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } rx_byte_t;

  // version byte layout
  typedef struct packed {
    logic [2:0] major;
    logic [4:0] minor;
  } version_t;

  // byte shifted out on MISO
  // get_version fills it through the version fields, everything else as a plain byte
  typedef union packed {
    logic [7:0] raw;
    version_t   version;
  } resp_byte_u;

endpackage

// ==== hdl/trs_macros.svh ====
`ifndef TRS_MACROS_SVH
`define TRS_MACROS_SVH

// identification byte returned for get_cookie
`define TRS_COOKIE 8'hAF

// firmware version reported by get_version
// major goes in the upper 3 bits, minor in the lower 5
`define TRS_VERSION_MAJOR 3'd0
`define TRS_VERSION_MINOR 5'd3

// flops between each SPI pin and the logic that uses it
`define TRS_SYNC_STAGES 3

// widest parameter list of any supported opcode
// set_screen_color needs all three
`define TRS_MAX_PARAMS 3

// keyboard matrix size
// rows are 8 bits wide, one bit per key
`define TRS_KEYB_ROWS 8

`endif
